// ==== rtl/idc_pkg.sv ====
package idc_pkg;

  localparam int instr_w = 32;
  localparam int imm_w = 16;
  localparam int reg_sel_w = 9;
  localparam int reg_w = 8;
  localparam int fn_w = 6;

  // Register select that addresses the program counter
  localparam logic [reg_sel_w-1:0] pc_sel = 9'h0FF;

  // Instruction word fields
  localparam int grp_hi = 31;
  localparam int grp_lo = 30;
  localparam int fn_hi = 29;
  localparam int fn_lo = 24;
  localparam int r1_hi = 23;
  localparam int r1_lo = 16;
  localparam int r2_hi = 15;
  localparam int r2_lo = 8;
  localparam int r3_hi = 7;
  localparam int r3_lo = 0;
  localparam int imm_hi = 15;
  localparam int imm_lo = 0;

  typedef enum logic [1:0] {
    grp_jmp_misc = 2'd0,
    grp_arith    = 2'd1,
    grp_logic    = 2'd2,
    grp_mem_man  = 2'd3
  } group_e;

  typedef enum logic [4:0] {
    nop, jmp, jez, jgz, jlz, hlt,
    add, sub,
    and_op, or_op, xor_op, sfl, sfr,
    mov, mvl, mvh, clr
  } op_e;

  // Function codes seen by the ALU
  typedef enum logic [8:0] {
    alu_chk = 9'h000,
    alu_add = 9'h040,
    alu_sub = 9'h041,
    alu_and = 9'h080,
    alu_or  = 9'h081,
    alu_xor = 9'h082,
    alu_sfl = 9'h083,
    alu_sfr = 9'h084
  } alu_fnct_e;

  typedef enum logic [2:0] {
    src_none = 3'd0,
    src_rtr  = 3'd1,
    src_alu  = 3'd2,
    src_dib  = 3'd3,
    src_imm  = 3'd4
  } rb_src_e;

  typedef enum logic [1:0] {
    hl_full = 2'd0,
    hl_low  = 2'd1,
    hl_high = 2'd2
  } hl_e;

  typedef enum logic [2:0] {
    f_idle, f_fetch, f_wait_mar, f_wait_ram_oe, f_wait_dib, f_wait_ir
  } fetch_state_e;

  typedef enum logic [2:0] {
    e_idle, e_alu_wait, e_reg_wait, e_pc_plus, e_pc_wait, e_jmp_wait, e_halt
  } exec_state_e;

  typedef struct packed {
    op_e              op;
    logic [reg_w-1:0] reg1;
    logic [reg_w-1:0] reg2;
    logic [reg_w-1:0] reg3;
    logic [imm_w-1:0] imm;
  } decoded_t;

  typedef struct packed {
    alu_fnct_e            alu_fnct;
    logic [reg_sel_w-1:0] alu_a_sel;
    logic [reg_sel_w-1:0] alu_b_sel;
    logic [reg_sel_w-1:0] rtr_sel;
    rb_src_e              rb_ip_sel;
    hl_e                  hl_sel;
    logic [reg_sel_w-1:0] rb_ip_reg_sel;
    logic [reg_sel_w-1:0] rb_reg_clr_sel;
  } route_t;

  typedef struct packed {
    logic ir_wr;
    logic mar_wr;
    logic ram_oe;
    logic alu_req;
    logic reg_wr;
    logic reg_clr;
    logic pc_incr;
    logic halt;
  } strobe_t;

  typedef struct packed {
    logic alu;
    logic reg_wr;
    logic mar_wr;
    logic ram_oe;
    logic ir_wr;
    logic dib;
  } ack_t;

  typedef struct packed {
    logic nf;
    logic zf;
  } flags_t;

endpackage

// ==== rtl/fetch_seq.sv ====
module fetch_seq (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic [idc_pkg::instr_w-1:0] instr,
  input  idc_pkg::ack_t              acks,
  input  logic                       done,
  output logic                       mar_wr,
  output logic                       ram_oe,
  output logic                       ir_wr,
  output logic                       word_valid,
  output logic [idc_pkg::instr_w-1:0] instr_word
);

  idc_pkg::fetch_state_e state;
  logic                  first;

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      state <= idc_pkg::f_idle;
      first <= 1'b1;
      mar_wr <= 1'b0;
      ram_oe <= 1'b0;
      ir_wr <= 1'b0;
      word_valid <= 1'b0;
    end
    else
    begin
      mar_wr <= 1'b0;
      ram_oe <= 1'b0;
      ir_wr <= 1'b0;
      word_valid <= 1'b0;
      case (state)
        // First fetch after reset, then one per finished instruction
        idc_pkg::f_idle:
        begin
          if (first || done)
          begin
            first <= 1'b0;
            state <= idc_pkg::f_fetch;
          end
        end
        idc_pkg::f_fetch:
        begin
          mar_wr <= 1'b1;
          state <= idc_pkg::f_wait_mar;
        end
        idc_pkg::f_wait_mar:
        begin
          if (acks.mar_wr)
          begin
            ram_oe <= 1'b1;
            state <= idc_pkg::f_wait_ram_oe;
          end
        end
        idc_pkg::f_wait_ram_oe:
        begin
          if (acks.ram_oe)
            state <= idc_pkg::f_wait_dib;
        end
        idc_pkg::f_wait_dib:
        begin
          if (acks.dib)
          begin
            ir_wr <= 1'b1;
            state <= idc_pkg::f_wait_ir;
          end
        end
        idc_pkg::f_wait_ir:
        begin
          if (acks.ir_wr)
          begin
            word_valid <= 1'b1;
            state <= idc_pkg::f_idle;
          end
        end
        default: state <= idc_pkg::f_idle;
      endcase
    end
  end

  // Instruction is valid on the IR write ack
  always_ff @(posedge clk)
  begin
    if (state == idc_pkg::f_wait_ir && acks.ir_wr)
      instr_word <= instr;
  end

endmodule

// ==== rtl/instr_decode.sv ====
module instr_decode (
  input  logic                        clk,
  input  logic                        rst_b,
  input  logic                        word_valid,
  input  logic [idc_pkg::instr_w-1:0] instr_word,
  output logic                        op_valid,
  output idc_pkg::decoded_t           decoded,
  output logic [idc_pkg::imm_w-1:0]   imme_out
);

  idc_pkg::group_e             grp;
  logic [idc_pkg::fn_w-1:0]    fn;

  assign grp = idc_pkg::group_e'(instr_word[idc_pkg::grp_hi:idc_pkg::grp_lo]);
  assign fn = instr_word[idc_pkg::fn_hi:idc_pkg::fn_lo];

  // Unknown group/function pairs fall back to nop
  function automatic idc_pkg::op_e decode_op(input idc_pkg::group_e g,
                                             input logic [idc_pkg::fn_w-1:0] f);
    idc_pkg::op_e op;
    op = idc_pkg::nop;
    case (g)
      idc_pkg::grp_jmp_misc:
      begin
        case (f)
          6'd1: op = idc_pkg::jmp;
          6'd2: op = idc_pkg::jez;
          6'd3: op = idc_pkg::jgz;
          6'd4: op = idc_pkg::jlz;
          6'd5: op = idc_pkg::hlt;
          default: op = idc_pkg::nop;
        endcase
      end
      idc_pkg::grp_arith:
      begin
        case (f)
          6'd0: op = idc_pkg::add;
          6'd1: op = idc_pkg::sub;
          default: op = idc_pkg::nop;
        endcase
      end
      idc_pkg::grp_logic:
      begin
        case (f)
          6'd0: op = idc_pkg::and_op;
          6'd1: op = idc_pkg::or_op;
          6'd2: op = idc_pkg::xor_op;
          6'd3: op = idc_pkg::sfl;
          6'd4: op = idc_pkg::sfr;
          default: op = idc_pkg::nop;
        endcase
      end
      default:
      begin
        // Codes 0 and 1 were the memory load and store
        case (f)
          6'd2: op = idc_pkg::mov;
          6'd3: op = idc_pkg::mvl;
          6'd4: op = idc_pkg::mvh;
          6'd5: op = idc_pkg::clr;
          default: op = idc_pkg::nop;
        endcase
      end
    endcase
    return op;
  endfunction

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
      op_valid <= 1'b0;
    else
      op_valid <= word_valid;
  end

  // Fields stay put until the next fetched word
  always_ff @(posedge clk)
  begin
    if (word_valid)
    begin
      decoded.op <= decode_op(grp, fn);
      decoded.reg1 <= instr_word[idc_pkg::r1_hi:idc_pkg::r1_lo];
      decoded.reg2 <= instr_word[idc_pkg::r2_hi:idc_pkg::r2_lo];
      decoded.reg3 <= instr_word[idc_pkg::r3_hi:idc_pkg::r3_lo];
      decoded.imm <= instr_word[idc_pkg::imm_hi:idc_pkg::imm_lo];
    end
  end

  assign imme_out = decoded.imm;

endmodule

// ==== rtl/exec_seq.sv ====
module exec_seq (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              op_valid,
  input  idc_pkg::decoded_t decoded,
  input  idc_pkg::ack_t     acks,
  input  idc_pkg::flags_t   flags,
  output logic              alu_req,
  output logic              reg_wr,
  output logic              reg_clr,
  output logic              pc_incr,
  output logic              halt,
  output idc_pkg::route_t   route,
  output logic              done
);

  idc_pkg::exec_state_e          state;
  idc_pkg::alu_fnct_e            fnct;
  logic                          two_op;
  logic                          is_branch;
  logic                          taken;
  logic [idc_pkg::reg_sel_w-1:0] r1_sel;
  logic [idc_pkg::reg_sel_w-1:0] r2_sel;
  logic [idc_pkg::reg_sel_w-1:0] r3_sel;

  assign r1_sel = {1'b0, decoded.reg1};
  assign r2_sel = {1'b0, decoded.reg2};
  assign r3_sel = {1'b0, decoded.reg3};

  assign two_op = decoded.op inside {idc_pkg::add, idc_pkg::sub, idc_pkg::and_op,
                                     idc_pkg::or_op, idc_pkg::xor_op};
  assign is_branch = decoded.op inside {idc_pkg::jez, idc_pkg::jgz, idc_pkg::jlz};

  // Flags are sampled with the ALU ack
  assign taken = (decoded.op == idc_pkg::jez && flags.zf) ||
                 (decoded.op == idc_pkg::jgz && !flags.zf && !flags.nf) ||
                 (decoded.op == idc_pkg::jlz && flags.nf);

  always_comb
  begin
    case (decoded.op)
      idc_pkg::add: fnct = idc_pkg::alu_add;
      idc_pkg::sub: fnct = idc_pkg::alu_sub;
      idc_pkg::and_op: fnct = idc_pkg::alu_and;
      idc_pkg::or_op: fnct = idc_pkg::alu_or;
      idc_pkg::xor_op: fnct = idc_pkg::alu_xor;
      idc_pkg::sfl: fnct = idc_pkg::alu_sfl;
      idc_pkg::sfr: fnct = idc_pkg::alu_sfr;
      default: fnct = idc_pkg::alu_chk;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      state <= idc_pkg::e_idle;
      route <= '0;
      alu_req <= 1'b0;
      reg_wr <= 1'b0;
      reg_clr <= 1'b0;
      pc_incr <= 1'b0;
      halt <= 1'b0;
      done <= 1'b0;
    end
    else
    begin
      alu_req <= 1'b0;
      reg_wr <= 1'b0;
      reg_clr <= 1'b0;
      pc_incr <= 1'b0;
      done <= 1'b0;
      case (state)
        idc_pkg::e_idle:
        begin
          if (op_valid)
          begin
            case (decoded.op)
              idc_pkg::nop: state <= idc_pkg::e_pc_plus;
              idc_pkg::hlt:
              begin
                halt <= 1'b1;
                state <= idc_pkg::e_halt;
              end
              idc_pkg::jmp:
              begin
                route.rtr_sel <= r1_sel;
                route.rb_ip_sel <= idc_pkg::src_rtr;
                route.hl_sel <= idc_pkg::hl_full;
                route.rb_ip_reg_sel <= idc_pkg::pc_sel;
                reg_wr <= 1'b1;
                state <= idc_pkg::e_jmp_wait;
              end
              idc_pkg::mov:
              begin
                route.rtr_sel <= r2_sel;
                route.rb_ip_sel <= idc_pkg::src_rtr;
                route.hl_sel <= idc_pkg::hl_full;
                route.rb_ip_reg_sel <= r1_sel;
                reg_wr <= 1'b1;
                state <= idc_pkg::e_reg_wait;
              end
              idc_pkg::mvl, idc_pkg::mvh:
              begin
                route.rb_ip_sel <= idc_pkg::src_imm;
                route.hl_sel <= (decoded.op == idc_pkg::mvh) ? idc_pkg::hl_high
                                                              : idc_pkg::hl_low;
                route.rb_ip_reg_sel <= r1_sel;
                reg_wr <= 1'b1;
                state <= idc_pkg::e_reg_wait;
              end
              idc_pkg::clr:
              begin
                route.rb_reg_clr_sel <= r1_sel;
                reg_clr <= 1'b1;
                state <= idc_pkg::e_pc_plus;
              end
              // ALU ops and the check pass of conditional branches
              default:
              begin
                route.alu_fnct <= fnct;
                route.alu_a_sel <= r1_sel;
                if (two_op)
                  route.alu_b_sel <= r2_sel;
                alu_req <= 1'b1;
                state <= idc_pkg::e_alu_wait;
              end
            endcase
          end
        end
        idc_pkg::e_alu_wait:
        begin
          if (acks.alu)
          begin
            if (is_branch && taken)
            begin
              route.rtr_sel <= r2_sel;
              route.rb_ip_sel <= idc_pkg::src_rtr;
              route.hl_sel <= idc_pkg::hl_full;
              route.rb_ip_reg_sel <= idc_pkg::pc_sel;
              reg_wr <= 1'b1;
              state <= idc_pkg::e_jmp_wait;
            end
            else if (is_branch)
              state <= idc_pkg::e_pc_plus;
            else
            begin
              // Shifts write back in place
              route.rb_ip_sel <= idc_pkg::src_alu;
              route.hl_sel <= idc_pkg::hl_full;
              route.rb_ip_reg_sel <= two_op ? r3_sel : r1_sel;
              reg_wr <= 1'b1;
              state <= idc_pkg::e_reg_wait;
            end
          end
        end
        idc_pkg::e_reg_wait:
        begin
          if (acks.reg_wr)
            state <= idc_pkg::e_pc_plus;
        end
        idc_pkg::e_pc_plus:
        begin
          route.rb_ip_reg_sel <= idc_pkg::pc_sel;
          pc_incr <= 1'b1;
          state <= idc_pkg::e_pc_wait;
        end
        idc_pkg::e_pc_wait, idc_pkg::e_jmp_wait:
        begin
          if (acks.reg_wr)
          begin
            done <= 1'b1;
            state <= idc_pkg::e_idle;
          end
        end
        // Halted until reset
        default: state <= idc_pkg::e_halt;
      endcase
    end
  end

endmodule

// ==== rtl/idc_top.sv ====
module idc_top (
  input  logic                        clk,
  input  logic                        rst_b,
  input  logic [idc_pkg::instr_w-1:0] instr,
  input  idc_pkg::ack_t               acks,
  input  idc_pkg::flags_t             flags,
  output idc_pkg::strobe_t            strobes,
  output idc_pkg::route_t             route,
  output logic [idc_pkg::imm_w-1:0]   imme_out
);

  logic                        mar_wr;
  logic                        ram_oe;
  logic                        ir_wr;
  logic                        alu_req;
  logic                        reg_wr;
  logic                        reg_clr;
  logic                        pc_incr;
  logic                        halt;
  logic                        word_valid;
  logic                        op_valid;
  logic                        done;
  logic [idc_pkg::instr_w-1:0] instr_word;
  idc_pkg::decoded_t           decoded;

  fetch_seq u_fetch_seq (
    .clk        (clk),
    .rst_b      (rst_b),
    .instr      (instr),
    .acks       (acks),
    .done       (done),
    .mar_wr     (mar_wr),
    .ram_oe     (ram_oe),
    .ir_wr      (ir_wr),
    .word_valid (word_valid),
    .instr_word (instr_word)
  );

  instr_decode u_instr_decode (
    .clk        (clk),
    .rst_b      (rst_b),
    .word_valid (word_valid),
    .instr_word (instr_word),
    .op_valid   (op_valid),
    .decoded    (decoded),
    .imme_out   (imme_out)
  );

  exec_seq u_exec_seq (
    .clk      (clk),
    .rst_b    (rst_b),
    .op_valid (op_valid),
    .decoded  (decoded),
    .acks     (acks),
    .flags    (flags),
    .alu_req  (alu_req),
    .reg_wr   (reg_wr),
    .reg_clr  (reg_clr),
    .pc_incr  (pc_incr),
    .halt     (halt),
    .route    (route),
    .done     (done)
  );

  assign strobes = '{ir_wr: ir_wr, mar_wr: mar_wr, ram_oe: ram_oe, alu_req: alu_req,
                     reg_wr: reg_wr, reg_clr: reg_clr, pc_incr: pc_incr, halt: halt};

endmodule

// ==== verif/idc_responder.sv ====
module idc_responder #(
  parameter int n = 64
) (
  input  logic                        clk,
  input  logic                        rst_b,
  input  idc_pkg::strobe_t            strobes,
  input  logic [idc_pkg::instr_w-1:0] prog [n],
  output logic [idc_pkg::instr_w-1:0] instr,
  output idc_pkg::ack_t               acks,
  output idc_pkg::flags_t             flags
);

  timeunit 1ns;
  timeprecision 100ps;

  // Pending acknowledge: 0 none, 1 mar, 2 ram_oe, 3 dib, 4 ir, 5 alu, 6 reg
  int          kind;
  int          wait_cnt;
  int          idx;
  logic [31:0] rng;

  function automatic logic [31:0] shift_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      acks <= '0;
      flags <= '0;
      instr <= '0;
      kind <= 0;
      wait_cnt <= 0;
      idx <= 0;
      rng <= 32'd78;
    end
    else
    begin
      acks <= '0;
      if (kind == 0)
      begin
        // Remaining delay of 0 to 3 gives an ack 1 to 4 cycles after the strobe
        wait_cnt <= int'(rng % 32'd4);
        rng <= shift_rand(rng);
        if (strobes.mar_wr)
          kind <= 1;
        else if (strobes.ram_oe)
          kind <= 2;
        else if (strobes.ir_wr)
          kind <= 4;
        else if (strobes.alu_req)
          kind <= 5;
        else if (strobes.reg_wr || strobes.pc_incr)
          kind <= 6;
      end
      else if (wait_cnt > 0)
        wait_cnt <= wait_cnt - 1;
      else
      begin
        kind <= 0;
        rng <= shift_rand(rng);
        case (kind)
          1: acks.mar_wr <= 1'b1;
          2:
          begin
            // Data bus ack follows the RAM read ack
            acks.ram_oe <= 1'b1;
            wait_cnt <= int'(rng % 32'd4);
            kind <= 3;
          end
          3: acks.dib <= 1'b1;
          4:
          begin
            acks.ir_wr <= 1'b1;
            instr <= (idx < n) ? prog[idx] : '0;
            idx <= idx + 1;
          end
          5:
          begin
            acks.alu <= 1'b1;
            flags <= rng[1:0];
          end
          default: acks.reg_wr <= 1'b1;
        endcase
      end
    end
  end

endmodule

// ==== verif/idc_tb.sv ====
module idc_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n = 64;
  localparam logic [8:0] pc_reg = 9'h0FF;

  logic                        clk = 1'b0;
  logic                        rst_b = 1'b0;
  logic [idc_pkg::instr_w-1:0] instr;
  idc_pkg::ack_t               acks;
  idc_pkg::flags_t             flags;
  idc_pkg::strobe_t            strobes;
  idc_pkg::route_t             route;
  logic [idc_pkg::imm_w-1:0]   imme_out;
  logic [31:0]                 prog [n];
  logic [31:0]                 cur_word = '0;
  idc_pkg::flags_t             saved_flags = '0;
  logic                        busy;
  logic                        finished;
  logic                        pulse;
  int                          fetched;
  int                          errors = 0;
  int                          timeouts = 0;

  // Group and function codes, the last of each group invalid or former LD and ST
  logic [7:0] codes [21] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h06,
                             8'h40, 8'h41, 8'h45,
                             8'h80, 8'h81, 8'h82, 8'h83, 8'h84, 8'h89,
                             8'hC0, 8'hC1, 8'hC2, 8'hC3, 8'hC4, 8'hC5};

  idc_top u_idc_top (
    .clk      (clk),
    .rst_b    (rst_b),
    .instr    (instr),
    .acks     (acks),
    .flags    (flags),
    .strobes  (strobes),
    .route    (route),
    .imme_out (imme_out)
  );

  idc_responder #(.n(n)) u_responder (
    .clk     (clk),
    .rst_b   (rst_b),
    .strobes (strobes),
    .prog    (prog),
    .instr   (instr),
    .acks    (acks),
    .flags   (flags)
  );

  initial
  begin
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic idc_pkg::op_e ref_op(input logic [31:0] w);
    logic [1:0] g;
    logic [5:0] f;
    g = w[31:30];
    f = w[29:24];
    ref_op = idc_pkg::nop;
    if (g == 2'd0 && f >= 6'd1 && f <= 6'd5)
      ref_op = idc_pkg::op_e'(f);
    else if (g == 2'd1 && f <= 6'd1)
      ref_op = idc_pkg::op_e'(6 + f);
    else if (g == 2'd2 && f <= 6'd4)
      ref_op = idc_pkg::op_e'(8 + f);
    else if (g == 2'd3 && f >= 6'd2 && f <= 6'd5)
      ref_op = idc_pkg::op_e'(11 + f);
  endfunction

  function automatic logic [8:0] alu_code(input idc_pkg::op_e op);
    case (op)
      idc_pkg::add: return 9'h040;
      idc_pkg::sub: return 9'h041;
      idc_pkg::and_op: return 9'h080;
      idc_pkg::or_op: return 9'h081;
      idc_pkg::xor_op: return 9'h082;
      idc_pkg::sfl: return 9'h083;
      idc_pkg::sfr: return 9'h084;
      default: return 9'h000;
    endcase
  endfunction

  function automatic logic two_operand(input idc_pkg::op_e op);
    return op inside {idc_pkg::add, idc_pkg::sub, idc_pkg::and_op, idc_pkg::or_op,
                      idc_pkg::xor_op};
  endfunction

  function automatic logic cond_branch(input idc_pkg::op_e op);
    return op inside {idc_pkg::jez, idc_pkg::jgz, idc_pkg::jlz};
  endfunction

  function automatic logic branch_taken(input idc_pkg::op_e op, input idc_pkg::flags_t fl);
    return (op == idc_pkg::jez && fl.zf) || (op == idc_pkg::jgz && !fl.zf && !fl.nf) ||
           (op == idc_pkg::jlz && fl.nf);
  endfunction

  function automatic logic write_ok(input logic [31:0] w, input idc_pkg::route_t r,
                                    input idc_pkg::flags_t fl);
    idc_pkg::op_e op;
    logic [8:0]   r1;
    logic [8:0]   r2;
    logic [8:0]   r3;
    logic         full_src;
    op = ref_op(w);
    r1 = {1'b0, w[23:16]};
    r2 = {1'b0, w[15:8]};
    r3 = {1'b0, w[7:0]};
    full_src = r.hl_sel == idc_pkg::hl_full;
    if (two_operand(op))
      return r.rb_ip_sel == idc_pkg::src_alu && full_src && r.rb_ip_reg_sel == r3;
    case (op)
      idc_pkg::sfl, idc_pkg::sfr:
        return r.rb_ip_sel == idc_pkg::src_alu && full_src && r.rb_ip_reg_sel == r1;
      idc_pkg::mov:
        return r.rb_ip_sel == idc_pkg::src_rtr && full_src && r.rb_ip_reg_sel == r1 &&
               r.rtr_sel == r2;
      idc_pkg::mvl, idc_pkg::mvh:
        return r.rb_ip_sel == idc_pkg::src_imm && r.rb_ip_reg_sel == r1 &&
               r.hl_sel == ((op == idc_pkg::mvl) ? idc_pkg::hl_low : idc_pkg::hl_high);
      idc_pkg::jmp:
        return r.rb_ip_sel == idc_pkg::src_rtr && full_src && r.rb_ip_reg_sel == pc_reg &&
               r.rtr_sel == r1;
      idc_pkg::jez, idc_pkg::jgz, idc_pkg::jlz:
        return branch_taken(op, fl) && r.rb_ip_sel == idc_pkg::src_rtr && full_src &&
               r.rb_ip_reg_sel == pc_reg && r.rtr_sel == r2;
      default: return 1'b0;
    endcase
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  assign pulse = strobes.ir_wr | strobes.mar_wr | strobes.ram_oe | strobes.alu_req |
                 strobes.reg_wr | strobes.pc_incr;

  // One strobe outstanding at a time, cleared by its final ack
  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      busy <= 1'b0;
      finished <= 1'b0;
      fetched <= 0;
    end
    else
    begin
      if (pulse)
        busy <= 1'b1;
      else if (acks.mar_wr || acks.dib || acks.ir_wr || acks.alu || acks.reg_wr)
        busy <= 1'b0;
      if (acks.ir_wr)
      begin
        cur_word <= instr;
        fetched <= fetched + 1;
        finished <= 1'b0;
      end
      else if (strobes.pc_incr || (strobes.reg_wr && route.rb_ip_reg_sel == pc_reg))
        finished <= 1'b1;
      if (acks.alu)
        saved_flags <= flags;
    end
  end

  a_reset: assert property (@(posedge clk) $rose(rst_b) |-> (strobes == '0 && route == '0))
    else report_error("strobes or route not zero after reset");
  a_ram_oe: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.ram_oe |-> $past(acks.mar_wr))
    else report_error("ram_oe without a preceding mar_wr ack");
  a_ir_wr: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.ir_wr |-> $past(acks.dib))
    else report_error("ir_wr without a preceding dib ack");
  a_repeat: assert property (@(posedge clk) disable iff (!rst_b) pulse |-> !busy)
    else report_error("strobe issued while another is outstanding");
  a_alu: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.alu_req |-> (route.alu_fnct == alu_code(ref_op(cur_word)) &&
      route.alu_a_sel == {1'b0, cur_word[23:16]} &&
      (!two_operand(ref_op(cur_word)) || route.alu_b_sel == {1'b0, cur_word[15:8]}) &&
      (two_operand(ref_op(cur_word)) || cond_branch(ref_op(cur_word)) ||
       ref_op(cur_word) inside {idc_pkg::sfl, idc_pkg::sfr})))
    else report_error("ALU request with wrong function or operands");
  a_write: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.reg_wr |-> write_ok(cur_word, route, saved_flags))
    else report_error("register write with wrong source, half or destination");
  a_clear: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.reg_clr |-> (ref_op(cur_word) == idc_pkg::clr &&
      route.rb_reg_clr_sel == {1'b0, cur_word[23:16]}))
    else report_error("register clear with wrong op or register");
  a_pc: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.pc_incr |-> (route.rb_ip_reg_sel == pc_reg &&
      !(ref_op(cur_word) inside {idc_pkg::jmp, idc_pkg::hlt}) &&
      !(cond_branch(ref_op(cur_word)) && branch_taken(ref_op(cur_word), saved_flags))))
    else report_error("unexpected PC advance");
  a_imm: assert property (@(posedge clk) disable iff (!rst_b)
    (strobes.alu_req || strobes.reg_wr || strobes.reg_clr || strobes.pc_incr) |->
      imme_out == cur_word[15:0])
    else report_error("imme_out differs from the low half of the word");
  a_finish: assert property (@(posedge clk) disable iff (!rst_b)
    (strobes.mar_wr && fetched > 0) |-> finished)
    else report_error("next fetch before the instruction finished");
  a_halt_op: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.halt |-> ref_op(cur_word) == idc_pkg::hlt)
    else report_error("halt raised for an op other than hlt");
  a_halt_hold: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.halt |=> strobes.halt)
    else report_error("halt dropped");
  a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_b)
    strobes.halt |-> !pulse && !strobes.reg_clr)
    else report_error("strobe after halt");

  initial
  begin
    logic [31:0] seed;
    int          cnt;
    seed = 32'd78;
    for (int i = 0; i < n - 1; i++)
    begin
      seed = next_rand(seed);
      prog[i] = {codes[i % 21], seed[23:0]};
    end
    prog[n - 1] = 32'h0500_0000;
    repeat (8) @(posedge clk);
    rst_b <= 1'b1;
    cnt = 0;
    while (!strobes.halt && cnt < 20000)
    begin
      @(posedge clk);
      cnt++;
    end
    if (!strobes.halt)
    begin
      timeouts++;
      $display("Timeout: the controller never reached halt");
    end
    // Quiet window after halt, checked by the halt assertions
    cnt = 0;
    while (cnt < 200)
    begin
      @(posedge clk);
      cnt++;
    end
    if (fetched != n)
      report_error($sformatf("fetched %0d words, expected %0d", fetched, n));
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/idc_pkg.sv
rtl/fetch_seq.sv
rtl/instr_decode.sv
rtl/exec_seq.sv
rtl/idc_top.sv
verif/idc_responder.sv
verif/idc_tb.sv

// ==== run.sh ====
#!/bin/bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module idc_tb -f all.f -o idc_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/idc_sim 2>&1 | tee sim.log
grep -qF "** FAIL **" sim.log && exit 1 || exit 0
